// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // ALU operation select, decoded from opcode/funct3/funct7 upstream
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_t;

    // Source of the value written back to the register file
    typedef enum logic [2:0] {
        res_alu = 3'd0,
        res_mem = 3'd1,
        res_pc4 = 3'd2,
        res_csr = 3'd3,
        res_mul = 3'd4
    } res_src_t;

    // Load/store access width, as carried in funct3
    localparam logic [2:0] f3_byte   = 3'd0;
    localparam logic [2:0] f3_half   = 3'd1;
    localparam logic [2:0] f3_word   = 3'd2;
    localparam logic [2:0] f3_byte_u = 3'd4;
    localparam logic [2:0] f3_half_u = 3'd5;

endpackage

// File: hdl/rv_pipe_pkg.sv
package rv_pipe_pkg;

    // Integer datapath width
    localparam int xlen = 32;

    // Register file index width, x0..x31
    localparam int reg_idx_w = 5;

    // Data memory size in 32-bit words
    localparam int dmem_words = 256;

    // Word address, taken from alu_result bits 9:2
    localparam int dmem_addr_w = 8;

endpackage

// File: hdl/rv_ex_stage.sv
`timescale 1ns/1ps

module rv_ex_stage (
    input  rv_isa_pkg::alu_op_t          alu_op_ex,
    input  logic                         alu_src_imm_ex,
    input  logic [rv_pipe_pkg::xlen-1:0] rs1_data_ex,
    input  logic [rv_pipe_pkg::xlen-1:0] rs2_data_ex,
    input  logic [rv_pipe_pkg::xlen-1:0] imm_ex,
    input  logic [rv_pipe_pkg::xlen-1:0] pc_ex,
    output logic [rv_pipe_pkg::xlen-1:0] alu_result_ex,
    output logic [rv_pipe_pkg::xlen-1:0] pc_plus4_ex
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;

    assign op_a = rs1_data_ex;

    // Immediate form vs register form
    assign op_b = alu_src_imm_ex ? imm_ex : rs2_data_ex;

    // Only the low five bits count for RV32 shifts
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op_ex)
            alu_add: begin
                alu_result_ex = op_a + op_b;
            end
            alu_sub: begin
                alu_result_ex = op_a - op_b;
            end
            alu_and:  alu_result_ex = op_a & op_b;
            alu_or:   alu_result_ex = op_a | op_b;
            alu_xor:  alu_result_ex = op_a ^ op_b;
            alu_sll:  alu_result_ex = op_a << shamt;
            alu_srl:  alu_result_ex = op_a >> shamt;
            alu_sra: begin
                alu_result_ex = $signed(op_a) >>> shamt;
            end
            alu_slt: begin
                alu_result_ex = {{(xlen - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            alu_sltu: begin
                alu_result_ex = {{(xlen - 1){1'b0}}, op_a < op_b};
            end
            default: begin
                alu_result_ex = '0;
            end
        endcase
    end

    // Link value for jal/jalr, written back via res_pc4
    assign pc_plus4_ex = pc_ex + xlen'(4);

endmodule

// File: hdl/rv_reg_ex_mem.sv
`timescale 1ns/1ps

module rv_reg_ex_mem #(
    parameter int PIPELINED = 1
) (
    input  logic                              clk,
    input  logic                              rst_n,

    // Control from EX
    input  logic                              reg_write_ex,
    input  logic                              mem_read_ex,
    input  logic                              mem_write_ex,
    input  rv_isa_pkg::res_src_t              res_src_ex,

    // Data from EX
    input  logic [2:0]                        funct3_ex,
    input  logic [rv_pipe_pkg::reg_idx_w-1:0] rd_ex,
    input  logic [rv_pipe_pkg::xlen-1:0]      alu_result_ex,
    input  logic [rv_pipe_pkg::xlen-1:0]      rs2_data_ex,
    input  logic [rv_pipe_pkg::xlen-1:0]      pc_plus4_ex,
    input  logic [rv_pipe_pkg::xlen-1:0]      csr_rdata_ex,
    input  logic [rv_pipe_pkg::xlen-1:0]      m_result_ex,

    // Control to MEM
    output logic                              reg_write_mem,
    output logic                              mem_read_mem,
    output logic                              mem_write_mem,
    output rv_isa_pkg::res_src_t              res_src_mem,

    // Data to MEM
    output logic [2:0]                        funct3_mem,
    output logic [rv_pipe_pkg::reg_idx_w-1:0] rd_mem,
    output logic [rv_pipe_pkg::xlen-1:0]      alu_result_mem,
    output logic [rv_pipe_pkg::xlen-1:0]      rs2_data_mem,
    output logic [rv_pipe_pkg::xlen-1:0]      pc_plus4_mem,
    output logic [rv_pipe_pkg::xlen-1:0]      csr_rdata_mem,
    output logic [rv_pipe_pkg::xlen-1:0]      m_result_mem
);

    if (PIPELINED != 0) begin : g_reg
        // Clearing these three turns the slot into a bubble
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                reg_write_mem <= 1'b0;
                mem_read_mem  <= 1'b0;
                mem_write_mem <= 1'b0;
            end else begin
                reg_write_mem <= reg_write_ex;
                mem_read_mem  <= mem_read_ex;
                mem_write_mem <= mem_write_ex;
            end
        end

        always_ff @(posedge clk) begin
            res_src_mem    <= res_src_ex;
            funct3_mem     <= funct3_ex;
            rd_mem         <= rd_ex;
            alu_result_mem <= alu_result_ex;
            rs2_data_mem   <= rs2_data_ex;
            pc_plus4_mem   <= pc_plus4_ex;
            csr_rdata_mem  <= csr_rdata_ex;
            m_result_mem   <= m_result_ex;
        end
    end else begin : g_comb
        // Stage collapsed, EX feeds MEM in the same cycle
        assign reg_write_mem  = reg_write_ex;
        assign mem_read_mem   = mem_read_ex;
        assign mem_write_mem  = mem_write_ex;
        assign res_src_mem    = res_src_ex;
        assign funct3_mem     = funct3_ex;
        assign rd_mem         = rd_ex;
        assign alu_result_mem = alu_result_ex;
        assign rs2_data_mem   = rs2_data_ex;
        assign pc_plus4_mem   = pc_plus4_ex;
        assign csr_rdata_mem  = csr_rdata_ex;
        assign m_result_mem   = m_result_ex;
    end

endmodule

// File: hdl/rv_mem_stage.sv
`timescale 1ns/1ps

module rv_mem_stage (
    input  logic                         clk,
    input  logic                         mem_read_mem,
    input  logic                         mem_write_mem,
    input  logic [2:0]                   funct3_mem,
    input  logic [rv_pipe_pkg::xlen-1:0] alu_result_mem,
    input  logic [rv_pipe_pkg::xlen-1:0] rs2_data_mem,
    output logic [rv_pipe_pkg::xlen-1:0] mem_rdata_mem
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [xlen-1:0]        mem [dmem_words];
    logic [dmem_addr_w-1:0] word_addr;
    logic [1:0]             byte_off;
    logic [xlen-1:0]        wdata;
    logic [xlen/8-1:0]      be;

    assign word_addr = alu_result_mem[dmem_addr_w+1:2];
    assign byte_off  = alu_result_mem[1:0];

    // Replicate store data so every lane holds the right bytes,
    // byte enables then pick the lane
    always_comb begin
        case (funct3_mem)
            f3_byte, f3_byte_u: begin
                wdata = {4{rs2_data_mem[7:0]}};
            end
            f3_half, f3_half_u: begin
                wdata = {2{rs2_data_mem[15:0]}};
            end
            default: begin
                wdata = rs2_data_mem;
            end
        endcase
    end

    // Low address bits finer than the access size are ignored
    always_comb begin
        case (funct3_mem)
            f3_byte, f3_byte_u: begin
                be = 4'b0001 << byte_off;
            end
            f3_half, f3_half_u: begin
                be = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            f3_word: begin
                be = 4'b1111;
            end
            default: begin
                be = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_write_mem) begin
            for (int i = 0; i < xlen / 8; i++) begin
                if (be[i]) begin
                    mem[word_addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    // Whole word out, WB extracts and extends the addressed part
    assign mem_rdata_mem = mem_read_mem ? mem[word_addr] : '0;

endmodule

// File: hdl/rv_reg_mem_wb.sv
`timescale 1ns/1ps

module rv_reg_mem_wb #(
    parameter int PIPELINED = 1
) (
    input  logic                              clk,
    input  logic                              rst_n,

    input  logic                              reg_write_mem,
    input  rv_isa_pkg::res_src_t              res_src_mem,
    input  logic [2:0]                        funct3_mem,
    input  logic [rv_pipe_pkg::reg_idx_w-1:0] rd_mem,
    input  logic [1:0]                        byte_off_mem,
    input  logic [rv_pipe_pkg::xlen-1:0]      alu_result_mem,
    input  logic [rv_pipe_pkg::xlen-1:0]      mem_rdata_mem,
    input  logic [rv_pipe_pkg::xlen-1:0]      pc_plus4_mem,
    input  logic [rv_pipe_pkg::xlen-1:0]      csr_rdata_mem,
    input  logic [rv_pipe_pkg::xlen-1:0]      m_result_mem,

    output logic                              reg_write_wb,
    output rv_isa_pkg::res_src_t              res_src_wb,
    output logic [2:0]                        funct3_wb,
    output logic [rv_pipe_pkg::reg_idx_w-1:0] rd_wb,
    output logic [1:0]                        byte_off_wb,
    output logic [rv_pipe_pkg::xlen-1:0]      alu_result_wb,
    output logic [rv_pipe_pkg::xlen-1:0]      mem_rdata_wb,
    output logic [rv_pipe_pkg::xlen-1:0]      pc_plus4_wb,
    output logic [rv_pipe_pkg::xlen-1:0]      csr_rdata_wb,
    output logic [rv_pipe_pkg::xlen-1:0]      m_result_wb
);

    if (PIPELINED != 0) begin : g_reg
        // Register file write enable, the only state that must come up clean
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                reg_write_wb <= 1'b0;
            end else begin
                reg_write_wb <= reg_write_mem;
            end
        end

        always_ff @(posedge clk) begin
            res_src_wb    <= res_src_mem;
            funct3_wb     <= funct3_mem;
            rd_wb         <= rd_mem;
            byte_off_wb   <= byte_off_mem;
            alu_result_wb <= alu_result_mem;
            mem_rdata_wb  <= mem_rdata_mem;
            pc_plus4_wb   <= pc_plus4_mem;
            csr_rdata_wb  <= csr_rdata_mem;
            m_result_wb   <= m_result_mem;
        end
    end else begin : g_comb
        assign reg_write_wb  = reg_write_mem;
        assign res_src_wb    = res_src_mem;
        assign funct3_wb     = funct3_mem;
        assign rd_wb         = rd_mem;
        assign byte_off_wb   = byte_off_mem;
        assign alu_result_wb = alu_result_mem;
        assign mem_rdata_wb  = mem_rdata_mem;
        assign pc_plus4_wb   = pc_plus4_mem;
        assign csr_rdata_wb  = csr_rdata_mem;
        assign m_result_wb   = m_result_mem;
    end

endmodule

// File: hdl/rv_wb_stage.sv
`timescale 1ns/1ps

module rv_wb_stage (
    input  rv_isa_pkg::res_src_t         res_src_wb,
    input  logic [2:0]                   funct3_wb,
    input  logic [1:0]                   byte_off_wb,
    input  logic [rv_pipe_pkg::xlen-1:0] alu_result_wb,
    input  logic [rv_pipe_pkg::xlen-1:0] mem_rdata_wb,
    input  logic [rv_pipe_pkg::xlen-1:0] pc_plus4_wb,
    input  logic [rv_pipe_pkg::xlen-1:0] csr_rdata_wb,
    input  logic [rv_pipe_pkg::xlen-1:0] m_result_wb,
    output logic [rv_pipe_pkg::xlen-1:0] result_wb
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [xlen-1:0] load_val;

    assign ld_byte = mem_rdata_wb[byte_off_wb*8 +: 8];
    assign ld_half = byte_off_wb[1] ? mem_rdata_wb[31:16] : mem_rdata_wb[15:0];

    // Sign or zero extend depending on the unsigned variants
    always_comb begin
        case (funct3_wb)
            f3_byte:   load_val = {{(xlen - 8){ld_byte[7]}}, ld_byte};
            f3_byte_u: load_val = {{(xlen - 8){1'b0}}, ld_byte};
            f3_half:   load_val = {{(xlen - 16){ld_half[15]}}, ld_half};
            f3_half_u: load_val = {{(xlen - 16){1'b0}}, ld_half};
            default:   load_val = mem_rdata_wb;
        endcase
    end

    always_comb begin
        case (res_src_wb)
            res_mem: result_wb = load_val;
            res_pc4: result_wb = pc_plus4_wb;
            res_csr: result_wb = csr_rdata_wb;
            res_mul: result_wb = m_result_wb;
            // res_alu and any unused code
            default: result_wb = alu_result_wb;
        endcase
    end

endmodule

// File: hdl/rv_ex_mem_wb.sv
`timescale 1ns/1ps

module rv_ex_mem_wb #(
    parameter int PIPELINED = 1
) (
    input  logic                              clk,
    input  logic                              rst_n,

    // Decoded instruction from ID
    input  logic                              reg_write,
    input  logic                              mem_read,
    input  logic                              mem_write,
    input  rv_isa_pkg::res_src_t              res_src,
    input  rv_isa_pkg::alu_op_t               alu_op,
    input  logic                              alu_src_imm,
    input  logic [2:0]                        funct3,
    input  logic [rv_pipe_pkg::reg_idx_w-1:0] rd,
    input  logic [rv_pipe_pkg::xlen-1:0]      rs1_data,
    input  logic [rv_pipe_pkg::xlen-1:0]      rs2_data,
    input  logic [rv_pipe_pkg::xlen-1:0]      imm,
    input  logic [rv_pipe_pkg::xlen-1:0]      pc,

    // Results from CSR file and multiplier
    input  logic [rv_pipe_pkg::xlen-1:0]      csr_rdata,
    input  logic [rv_pipe_pkg::xlen-1:0]      m_result,

    // Register file write port
    output logic                              reg_write_wb,
    output logic [rv_pipe_pkg::reg_idx_w-1:0] rd_wb,
    output logic [rv_pipe_pkg::xlen-1:0]      result_wb
);

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    logic [xlen-1:0]      alu_result_ex;
    logic [xlen-1:0]      pc_plus4_ex;

    logic                 reg_write_mem;
    logic                 mem_read_mem;
    logic                 mem_write_mem;
    res_src_t             res_src_mem;
    logic [2:0]           funct3_mem;
    logic [reg_idx_w-1:0] rd_mem;
    logic [xlen-1:0]      alu_result_mem;
    logic [xlen-1:0]      rs2_data_mem;
    logic [xlen-1:0]      pc_plus4_mem;
    logic [xlen-1:0]      csr_rdata_mem;
    logic [xlen-1:0]      m_result_mem;
    logic [xlen-1:0]      mem_rdata_mem;

    res_src_t             res_src_wb;
    logic [2:0]           funct3_wb;
    logic [1:0]           byte_off_wb;
    logic [xlen-1:0]      alu_result_wb;
    logic [xlen-1:0]      mem_rdata_wb;
    logic [xlen-1:0]      pc_plus4_wb;
    logic [xlen-1:0]      csr_rdata_wb;
    logic [xlen-1:0]      m_result_wb;

    rv_ex_stage u_ex (
        .alu_op_ex      (alu_op),
        .alu_src_imm_ex (alu_src_imm),
        .rs1_data_ex    (rs1_data),
        .rs2_data_ex    (rs2_data),
        .imm_ex         (imm),
        .pc_ex          (pc),
        .alu_result_ex  (alu_result_ex),
        .pc_plus4_ex    (pc_plus4_ex)
    );

    rv_reg_ex_mem #(
        .PIPELINED (PIPELINED)
    ) u_reg_ex_mem (
        .clk            (clk),
        .rst_n          (rst_n),
        .reg_write_ex   (reg_write),
        .mem_read_ex    (mem_read),
        .mem_write_ex   (mem_write),
        .res_src_ex     (res_src),
        .funct3_ex      (funct3),
        .rd_ex          (rd),
        .alu_result_ex  (alu_result_ex),
        .rs2_data_ex    (rs2_data),
        .pc_plus4_ex    (pc_plus4_ex),
        .csr_rdata_ex   (csr_rdata),
        .m_result_ex    (m_result),
        .reg_write_mem  (reg_write_mem),
        .mem_read_mem   (mem_read_mem),
        .mem_write_mem  (mem_write_mem),
        .res_src_mem    (res_src_mem),
        .funct3_mem     (funct3_mem),
        .rd_mem         (rd_mem),
        .alu_result_mem (alu_result_mem),
        .rs2_data_mem   (rs2_data_mem),
        .pc_plus4_mem   (pc_plus4_mem),
        .csr_rdata_mem  (csr_rdata_mem),
        .m_result_mem   (m_result_mem)
    );

    rv_mem_stage u_mem (
        .clk            (clk),
        .mem_read_mem   (mem_read_mem),
        .mem_write_mem  (mem_write_mem),
        .funct3_mem     (funct3_mem),
        .alu_result_mem (alu_result_mem),
        .rs2_data_mem   (rs2_data_mem),
        .mem_rdata_mem  (mem_rdata_mem)
    );

    // Byte offset rides along for load extraction in WB
    rv_reg_mem_wb #(
        .PIPELINED (PIPELINED)
    ) u_reg_mem_wb (
        .clk            (clk),
        .rst_n          (rst_n),
        .reg_write_mem  (reg_write_mem),
        .res_src_mem    (res_src_mem),
        .funct3_mem     (funct3_mem),
        .rd_mem         (rd_mem),
        .byte_off_mem   (alu_result_mem[1:0]),
        .alu_result_mem (alu_result_mem),
        .mem_rdata_mem  (mem_rdata_mem),
        .pc_plus4_mem   (pc_plus4_mem),
        .csr_rdata_mem  (csr_rdata_mem),
        .m_result_mem   (m_result_mem),
        .reg_write_wb   (reg_write_wb),
        .res_src_wb     (res_src_wb),
        .funct3_wb      (funct3_wb),
        .rd_wb          (rd_wb),
        .byte_off_wb    (byte_off_wb),
        .alu_result_wb  (alu_result_wb),
        .mem_rdata_wb   (mem_rdata_wb),
        .pc_plus4_wb    (pc_plus4_wb),
        .csr_rdata_wb   (csr_rdata_wb),
        .m_result_wb    (m_result_wb)
    );

    rv_wb_stage u_wb (
        .res_src_wb    (res_src_wb),
        .funct3_wb     (funct3_wb),
        .byte_off_wb   (byte_off_wb),
        .alu_result_wb (alu_result_wb),
        .mem_rdata_wb  (mem_rdata_wb),
        .pc_plus4_wb   (pc_plus4_wb),
        .csr_rdata_wb  (csr_rdata_wb),
        .m_result_wb   (m_result_wb),
        .result_wb     (result_wb)
    );

endmodule

// File: bench/rv_ex_mem_wb_tb.sv
`timescale 1ns/1ps

module rv_ex_mem_wb_tb;

    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;

    localparam int clk_period  = 8;
    localparam int n_idle      = 8;
    localparam int n_alu       = 80;
    localparam int n_mem_words = 4;
    localparam int n_mix       = 80;
    // Each memory word: three stores, each followed by 13 loads
    localparam int n_total = n_idle + n_alu + n_mem_words * 42 + n_mix + 2;

    typedef struct packed {
        logic                 en;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      val;
    } wb_exp_t;

    logic                 clk;
    logic                 rst_n;
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    res_src_t             res_src;
    alu_op_t              alu_op;
    logic                 alu_src_imm;
    logic [2:0]           funct3;
    logic [reg_idx_w-1:0] rd;
    logic [xlen-1:0]      rs1_data;
    logic [xlen-1:0]      rs2_data;
    logic [xlen-1:0]      imm;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      csr_rdata;
    logic [xlen-1:0]      m_result;
    logic                 reg_write_wb;
    logic [reg_idx_w-1:0] rd_wb;
    logic [xlen-1:0]      result_wb;

    logic [15:0]     lfsr_state;
    logic [xlen-1:0] model_mem [dmem_words];
    logic [7:0]      words [n_mem_words];
    wb_exp_t         exp_q [$];
    int              err_count;
    int              check_count;

    rv_ex_mem_wb #(
        .PIPELINED (1)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .reg_write    (reg_write),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .res_src      (res_src),
        .alu_op       (alu_op),
        .alu_src_imm  (alu_src_imm),
        .funct3       (funct3),
        .rd           (rd),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .imm          (imm),
        .pc           (pc),
        .csr_rdata    (csr_rdata),
        .m_result     (m_result),
        .reg_write_wb (reg_write_wb),
        .rd_wb        (rd_wb),
        .result_wb    (result_wb)
    );

    always #(clk_period / 2) clk = ~clk;

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] alu_model(alu_op_t op, logic [31:0] a, logic [31:0] b);
        int unsigned sh;
        sh = b % 32;
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << sh;
            alu_srl:  return a >> sh;
            alu_sra:  return $signed(a) >>> sh;
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:  return (a < b) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] load_model(logic [31:0] word, logic [2:0] f3,
                                               logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        // Half position set by address bit 1 only
        h = word[16*off[1] +: 16];
        case (f3)
            f3_byte:   return {{24{b[7]}}, b};
            f3_byte_u: return {24'b0, b};
            f3_half:   return {{16{h[15]}}, h};
            f3_half_u: return {16'b0, h};
            default:   return word;
        endcase
    endfunction

    task automatic store_model(logic [7:0] w, logic [1:0] off, logic [2:0] f3,
                               logic [31:0] data);
        case (f3)
            f3_byte: model_mem[w][8*off +: 8] = data[7:0];
            f3_half: model_mem[w][16*off[1] +: 16] = data[15:0];
            default: model_mem[w] = data;
        endcase
    endtask

    task automatic report_mismatch(string field, logic [31:0] exp, logic [31:0] act);
        err_count++;
        $display("** Error at time %0t: %s expected %h, got %h", $time, field, exp, act);
    endtask

    task automatic push_expected(logic en, logic [reg_idx_w-1:0] r, logic [31:0] v);
        wb_exp_t e;
        e.en  = en;
        e.rd  = r;
        e.val = v;
        exp_q.push_back(e);
    endtask

    // WB outputs come from registers, so they are stable at the falling edge
    task automatic begin_slot();
        wb_exp_t e;
        @(negedge clk);
        e = exp_q.pop_front();
        check_count++;
        assert (reg_write_wb === e.en)
            else report_mismatch("reg_write_wb", 32'(e.en), 32'(reg_write_wb));
        if (e.en) begin
            assert (rd_wb === e.rd)
                else report_mismatch("rd_wb", 32'(e.rd), 32'(rd_wb));
            assert (result_wb === e.val)
                else report_mismatch("result_wb", e.val, result_wb);
        end
    endtask

    // Random data everywhere, all three control bits low
    task automatic randomize_inputs();
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        res_src     = res_src_t'(take_bits(3) % 5);
        alu_op      = alu_op_t'(take_bits(4) % 10);
        alu_src_imm = 1'(take_bits(1));
        funct3      = 3'(take_bits(3));
        rd          = reg_idx_w'(take_bits(reg_idx_w));
        rs1_data    = take_bits(32);
        rs2_data    = take_bits(32);
        imm         = take_bits(32);
        pc          = take_bits(32);
        csr_rdata   = take_bits(32);
        m_result    = take_bits(32);
    endtask

    task automatic do_idle();
        begin_slot();
        randomize_inputs();
        push_expected(1'b0, rd, 32'd0);
    endtask

    task automatic do_alu(alu_op_t op, logic en);
        begin_slot();
        randomize_inputs();
        reg_write = en;
        res_src   = res_alu;
        alu_op    = op;
        push_expected(en, rd, alu_model(op, rs1_data, alu_src_imm ? imm : rs2_data));
    endtask

    task automatic set_address(logic [7:0] w, logic [1:0] off);
        alu_op      = alu_add;
        alu_src_imm = 1'b1;
        rs1_data    = {22'(take_bits(22)), w, 2'b00};
        imm         = {30'b0, off};
    endtask

    task automatic do_store(logic [7:0] w, logic [1:0] off, logic [2:0] f3,
                            logic [31:0] data);
        begin_slot();
        randomize_inputs();
        mem_write = 1'b1;
        funct3    = f3;
        rs2_data  = data;
        set_address(w, off);
        store_model(w, off, f3, data);
        push_expected(1'b0, rd, 32'd0);
    endtask

    task automatic do_load(logic [7:0] w, logic [1:0] off, logic [2:0] f3);
        begin_slot();
        randomize_inputs();
        reg_write = 1'b1;
        mem_read  = 1'b1;
        res_src   = res_mem;
        funct3    = f3;
        set_address(w, off);
        push_expected(1'b1, rd, load_model(model_mem[w], f3, off));
    endtask

    task automatic do_side(res_src_t src, logic en);
        logic [31:0] v;
        begin_slot();
        randomize_inputs();
        reg_write = en;
        res_src   = src;
        case (src)
            res_pc4: v = pc + 32'd4;
            res_csr: v = csr_rdata;
            default: v = m_result;
        endcase
        push_expected(en, rd, v);
    endtask

    // Every width and offset from one word, 13 loads
    task automatic read_back(logic [7:0] w);
        do_load(w, 2'd0, f3_word);
        for (int off = 0; off < 4; off += 2) begin
            do_load(w, 2'(off), f3_half);
            do_load(w, 2'(off), f3_half_u);
        end
        for (int off = 0; off < 4; off++) begin
            do_load(w, 2'(off), f3_byte);
            do_load(w, 2'(off), f3_byte_u);
        end
    endtask

    initial begin
        #((n_total + 20) * clk_period);
        $display("Run timed out before all instructions completed");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int         kind;
        logic       en;
        logic [2:0] f3;
        clk         = 1'b0;
        rst_n       = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        res_src     = res_alu;
        alu_op      = alu_add;
        alu_src_imm = 1'b0;
        funct3      = 3'd0;
        rd          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        imm         = '0;
        pc          = '0;
        csr_rdata   = '0;
        m_result    = '0;
        lfsr_state  = 16'd5;
        err_count   = 0;
        check_count = 0;

        repeat (5) begin
            @(negedge clk);
            assert (reg_write_wb === 1'b0)
                else report_mismatch("reg_write_wb in reset", 32'd0, 32'(reg_write_wb));
        end
        rst_n = 1'b1;

        // Both stage registers hold bubbles right after reset
        push_expected(1'b0, '0, 32'd0);
        push_expected(1'b0, '0, 32'd0);

        repeat (n_idle) do_idle();

        for (int i = 0; i < n_alu; i++) begin
            do_alu(alu_op_t'(i % 10), 1'b1);
        end

        for (int k = 0; k < n_mem_words; k++) begin
            words[k] = 8'(take_bits(8));
            do_store(words[k], 2'd0, f3_word, take_bits(32));
            read_back(words[k]);
            do_store(words[k], {1'(take_bits(1)), 1'b0}, f3_half, take_bits(32) | 32'h8000);
            read_back(words[k]);
            do_store(words[k], 2'(take_bits(2)), f3_byte, take_bits(32) | 32'h80);
            read_back(words[k]);
        end

        for (int i = 0; i < n_mix; i++) begin
            kind = int'(take_bits(3) % 6);
            en   = take_bits(2) != 0;
            case (kind)
                0: do_alu(alu_op_t'(take_bits(4) % 10), en);
                1: begin
                    // Skip the unused codes 3 between word and byte_u
                    f3 = 3'(take_bits(3) % 5);
                    if (f3 > 3'd2) begin
                        f3 = f3 + 3'd1;
                    end
                    do_load(words[take_bits(2)], 2'(take_bits(2)), f3);
                end
                2: do_store(words[take_bits(2)], 2'(take_bits(2)), 3'(take_bits(2) % 3),
                            take_bits(32));
                3: do_side(res_pc4, en);
                4: do_side(res_csr, en);
                default: do_side(res_mul, en);
            endcase
        end

        // Flush the last two instructions to writeback
        do_idle();
        do_idle();

        $display("Checked %0d writebacks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: build.f
hdl/rv_isa_pkg.sv
hdl/rv_pipe_pkg.sv
hdl/rv_ex_stage.sv
hdl/rv_reg_ex_mem.sv
hdl/rv_mem_stage.sv
hdl/rv_reg_mem_wb.sv
hdl/rv_wb_stage.sv
hdl/rv_ex_mem_wb.sv
bench/rv_ex_mem_wb_tb.sv
